// File: rtl/function_generator_pkg.sv
package function_generator_pkg;

	// default sample width, matches one serializer word
	localparam int data_bus_width = 8;

	// default address width, 1024 words of waveform memory
	localparam int address_bus_depth = 10;

	// lfsr register length
	localparam int prbs_width = 31;

	// one waveform sample
	typedef logic [data_bus_width-1:0] sample_t;

	// one waveform memory address
	typedef logic [address_bus_depth-1:0] address_t;

	// lfsr start value, must be nonzero
	localparam logic [prbs_width-1:0] prbs_seed = 31'h5a5a1234;

	// loader sequence
	// idle for one cycle after reset, then fill every address, then done
	typedef enum logic [1:0] {
		idle,
		fill,
		done
	} loader_state_t;

endpackage

// File: rtl/prbs.sv
`timescale 1ns/10ps

module prbs #(
	parameter int DATA_BUS_WIDTH = function_generator_pkg::data_bus_width
) (
	input logic clock,
	input logic reset,
	output function_generator_pkg::sample_t word
);

	localparam int width = function_generator_pkg::prbs_width;
	// feedback taps at bits 31 and 28, counted from one
	localparam int tap_high = 30;
	localparam int tap_low = 27;

	logic [width-1:0] state;
	logic [width-1:0] next_state;

	// step the register once per output bit
	// first new bit ends up in the word msb
	always_comb begin
		next_state = state;
		for (int i = 0; i < DATA_BUS_WIDTH; i++) begin
			next_state = {next_state[width-2:0], next_state[tap_high] ^ next_state[tap_low]};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= function_generator_pkg::prbs_seed;
			word <= '0;
		end else begin
			state <= next_state;
			// newest bits sit at the bottom of the register
			word <= next_state[DATA_BUS_WIDTH-1:0];
		end
	end

endmodule

// File: rtl/waveform_loader.sv
`timescale 1ns/10ps

module waveform_loader #(
	parameter int ADDRESS_BUS_DEPTH = function_generator_pkg::address_bus_depth
) (
	input logic clock,
	input logic reset,
	input function_generator_pkg::sample_t word,
	output logic fill_enable,
	output function_generator_pkg::address_t fill_address,
	output function_generator_pkg::sample_t fill_data,
	output logic loaded
);

	// highest memory address
	localparam function_generator_pkg::address_t last_address =
		function_generator_pkg::address_t'((1 << ADDRESS_BUS_DEPTH) - 1);

	function_generator_pkg::loader_state_t state;
	// next address to be written
	function_generator_pkg::address_t fill_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= function_generator_pkg::idle;
			fill_count <= '0;
			fill_enable <= 1'b0;
			loaded <= 1'b0;
		end else begin
			case (state)
				// one quiet cycle while the lfsr produces its first word
				function_generator_pkg::idle: begin
					fill_count <= '0;
					fill_enable <= 1'b0;
					state <= function_generator_pkg::fill;
				end
				// register one word per cycle, no back-pressure
				function_generator_pkg::fill: begin
					fill_enable <= 1'b1;
					fill_count <= fill_count + 1'b1;
					if (fill_count == last_address) begin
						state <= function_generator_pkg::done;
					end
				end
				// last write lands this cycle, loaded follows it
				function_generator_pkg::done: begin
					fill_enable <= 1'b0;
					loaded <= 1'b1;
				end
				default: begin
					state <= function_generator_pkg::idle;
				end
			endcase
		end
	end

	// write payload, no reset needed
	always_ff @(posedge clock) begin
		fill_address <= fill_count;
		fill_data <= word;
	end

endmodule

// File: rtl/function_generator.sv
`timescale 1ns/10ps

module function_generator #(
	parameter int ADDRESS_BUS_DEPTH = function_generator_pkg::address_bus_depth
) (
	input logic clock,
	input logic reset,
	input logic loaded,
	input logic fill_enable,
	input function_generator_pkg::address_t fill_address,
	input function_generator_pkg::sample_t fill_data,
	input logic write_valid,
	output logic write_ready,
	input function_generator_pkg::address_t write_address,
	input function_generator_pkg::sample_t write_data,
	output logic sample_valid,
	input logic sample_ready,
	output function_generator_pkg::sample_t sample
);

	localparam int depth = 1 << ADDRESS_BUS_DEPTH;

	function_generator_pkg::sample_t memory [depth];

	// shared write port
	logic memory_write;
	function_generator_pkg::address_t memory_address;
	function_generator_pkg::sample_t memory_data;

	// playback side
	function_generator_pkg::address_t play_address;
	function_generator_pkg::sample_t prefetch;
	logic prefetch_valid;
	logic advance;
	logic fetch;

	// host is held off until the fill is over
	assign write_ready = loaded;

	// loader owns the port before loaded, host after
	always_comb begin
		if (loaded) begin
			memory_write = write_valid && write_ready;
			memory_address = write_address;
			memory_data = write_data;
		end else begin
			memory_write = fill_enable;
			memory_address = fill_address;
			memory_data = fill_data;
		end
	end

	always_ff @(posedge clock) begin
		if (memory_write) begin
			memory[memory_address] <= memory_data;
		end
	end

	// move prefetch into the output slot when it is empty or leaving
	assign advance = prefetch_valid && (!sample_valid || sample_ready);
	// refill prefetch whenever it is empty or being consumed
	assign fetch = loaded && (!prefetch_valid || advance);

	always_ff @(posedge clock) begin
		if (reset) begin
			play_address <= '0;
			prefetch_valid <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			if (fetch) begin
				// wraps from the top address back to 0
				play_address <= play_address + 1'b1;
				prefetch_valid <= 1'b1;
			end else if (advance) begin
				prefetch_valid <= 1'b0;
			end
			if (advance) begin
				sample_valid <= 1'b1;
			end else if (sample_ready) begin
				sample_valid <= 1'b0;
			end
		end
	end

	// registered read, one word ahead of the output
	always_ff @(posedge clock) begin
		if (fetch) begin
			prefetch <= memory[play_address];
		end
		if (advance) begin
			sample <= prefetch;
		end
	end

endmodule

// File: rtl/word_serializer.sv
`timescale 1ns/10ps

module word_serializer #(
	parameter int DATA_BUS_WIDTH = function_generator_pkg::data_bus_width
) (
	input logic clock,
	input logic reset,
	input logic sample_valid,
	output logic sample_ready,
	input function_generator_pkg::sample_t sample,
	output logic bit_out,
	output function_generator_pkg::sample_t data_out,
	output logic sample_strobe
);

	localparam int count_width = $clog2(DATA_BUS_WIDTH);
	localparam int last_bit = DATA_BUS_WIDTH - 1;

	// bits still to go, msb on top
	function_generator_pkg::sample_t shift;
	logic [count_width-1:0] bit_count;
	logic busy;
	logic sending_last;
	logic take;

	assign sending_last = busy && (bit_count == count_width'(last_bit));
	// free, or about to be free
	assign sample_ready = !busy || sending_last;
	assign take = sample_valid && sample_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			bit_count <= '0;
			bit_out <= 1'b0;
			sample_strobe <= 1'b0;
		end else begin
			sample_strobe <= take;
			if (take) begin
				// msb goes straight out, rest waits in the shifter
				busy <= 1'b1;
				bit_count <= '0;
				bit_out <= sample[DATA_BUS_WIDTH-1];
			end else if (sending_last) begin
				busy <= 1'b0;
				bit_out <= 1'b0;
			end else if (busy) begin
				bit_count <= bit_count + 1'b1;
				bit_out <= shift[DATA_BUS_WIDTH-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			shift <= {sample[DATA_BUS_WIDTH-2:0], 1'b0};
			data_out <= sample;
		end else begin
			shift <= {shift[DATA_BUS_WIDTH-2:0], 1'b0};
		end
	end

endmodule

// File: rtl/function_generator_althea.sv
`timescale 1ns/10ps

module function_generator_althea #(
	parameter int DATA_BUS_WIDTH = function_generator_pkg::data_bus_width,
	parameter int ADDRESS_BUS_DEPTH = function_generator_pkg::address_bus_depth
) (
	input logic clock,
	input logic reset,
	input logic write_valid,
	output logic write_ready,
	input function_generator_pkg::address_t write_address,
	input function_generator_pkg::sample_t write_data,
	output logic loaded,
	output logic bit_out,
	output function_generator_pkg::sample_t data_out,
	output logic sample_strobe
);

	// lfsr to loader
	function_generator_pkg::sample_t word;

	// loader to memory write port
	logic fill_enable;
	function_generator_pkg::address_t fill_address;
	function_generator_pkg::sample_t fill_data;

	// playback to serializer
	logic sample_valid;
	logic sample_ready;
	function_generator_pkg::sample_t sample;

	prbs #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH)
	) u_prbs (
		.clock(clock),
		.reset(reset),
		.word(word)
	);

	waveform_loader #(
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH)
	) u_waveform_loader (
		.clock(clock),
		.reset(reset),
		.word(word),
		.fill_enable(fill_enable),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.loaded(loaded)
	);

	function_generator #(
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH)
	) u_function_generator (
		.clock(clock),
		.reset(reset),
		.loaded(loaded),
		.fill_enable(fill_enable),
		.fill_address(fill_address),
		.fill_data(fill_data),
		.write_valid(write_valid),
		.write_ready(write_ready),
		.write_address(write_address),
		.write_data(write_data),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample)
	);

	// data_out doubles as the parallel sample output
	word_serializer #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH)
	) u_word_serializer (
		.clock(clock),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample(sample),
		.bit_out(bit_out),
		.data_out(data_out),
		.sample_strobe(sample_strobe)
	);

endmodule

// File: bench/function_generator_althea_asserts.sv
`timescale 1ns/10ps

module function_generator_althea_asserts #(
	parameter int DATA_BUS_WIDTH = function_generator_pkg::data_bus_width
) (
	input logic clock,
	input logic reset,
	input logic sample_valid,
	input logic sample_ready,
	input function_generator_pkg::sample_t sample,
	input logic sample_strobe,
	input logic loaded,
	input logic write_ready
);

	// cycles since the last strobe
	int strobe_gap;
	// first word has gone out
	logic playing;

	always_ff @(posedge clock) begin
		if (reset) begin
			strobe_gap <= 0;
			playing <= 1'b0;
		end else if (sample_strobe) begin
			strobe_gap <= 1;
			playing <= 1'b1;
		end else begin
			strobe_gap <= strobe_gap + 1;
		end
	end

	// held word stays put under back-pressure
	assert property (@(posedge clock) disable iff (reset)
		sample_valid && !sample_ready |=> sample_valid && $stable(sample))
	else $error("sample or sample_valid changed while sample_ready was low");

	// strobes exactly one word apart
	assert property (@(posedge clock) disable iff (reset)
		sample_strobe && playing |-> strobe_gap == DATA_BUS_WIDTH)
	else $error("sample_strobe came %0d cycles after the previous one", strobe_gap);

	// no gap longer than one word
	assert property (@(posedge clock) disable iff (reset)
		playing |-> strobe_gap <= DATA_BUS_WIDTH)
	else $error("sample_strobe missing after %0d cycles", strobe_gap);

	assert property (@(posedge clock) disable iff (reset)
		!loaded |-> !write_ready)
	else $error("write_ready high before loaded");

endmodule

bind function_generator_althea function_generator_althea_asserts #(
	.DATA_BUS_WIDTH(DATA_BUS_WIDTH)
) u_asserts (
	.clock(clock),
	.reset(reset),
	.sample_valid(sample_valid),
	.sample_ready(sample_ready),
	.sample(sample),
	.sample_strobe(sample_strobe),
	.loaded(loaded),
	.write_ready(write_ready)
);

// File: bench/function_generator_althea_tb.sv
`timescale 1ns/10ps

module function_generator_althea_tb;

	localparam int data_width = function_generator_pkg::data_bus_width;
	localparam int address_width = function_generator_pkg::address_bus_depth;
	localparam int depth = 1 << address_width;
	localparam int reset_cycles = 16;
	// reset release to loaded
	localparam int fill_cycles = 2 + depth;
	localparam int loop_cycles = depth * data_width;
	localparam int strobe_timeout = 4 * data_width;
	// two fills, three memory loops, margin
	localparam int watchdog_cycles = 2 * (reset_cycles + fill_cycles) + 3 * loop_cycles + 2000;

	logic clock;
	logic reset;
	logic write_valid;
	logic write_ready;
	function_generator_pkg::address_t write_address;
	function_generator_pkg::sample_t write_data;
	logic loaded;
	logic bit_out;
	function_generator_pkg::sample_t data_out;
	logic sample_strobe;

	// expected memory contents
	function_generator_pkg::sample_t model [depth];
	// address expected at the next strobe
	function_generator_pkg::address_t play_address;
	logic [31:0] random_state;
	string test_name;
	int test_errors;
	int error_count;
	int check_count;
	int test_count;

	function_generator_althea u_function_generator_althea (
		.clock(clock),
		.reset(reset),
		.write_valid(write_valid),
		.write_ready(write_ready),
		.write_address(write_address),
		.write_data(write_data),
		.loaded(loaded),
		.bit_out(bit_out),
		.data_out(data_out),
		.sample_strobe(sample_strobe)
	);

	always #50 clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] random_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			random_state = random_step(random_state);
			value = {value[30:0], random_state[0]};
		end
	endtask

	// 31-bit lfsr, taps 31 and 28, shift left
	// one word per address with the first new bit in the msb
	task automatic build_model();
		logic [30:0] state;
		logic feedback;
		function_generator_pkg::sample_t word;
		state = 31'h5a5a1234;
		for (int a = 0; a < depth; a++) begin
			word = '0;
			for (int b = 0; b < data_width; b++) begin
				feedback = state[30] ^ state[27];
				state = {state[29:0], feedback};
				word = {word[data_width-2:0], feedback};
			end
			model[a] = word;
		end
		play_address = '0;
	endtask

	task automatic compare_sample(input string what,
			input function_generator_pkg::sample_t expected,
			input function_generator_pkg::sample_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s (%s): expected %h, actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic compare_bit(input string what, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s (%s): expected %b, actual %b",
				test_name, what, expected, actual);
		end
	endtask

	task automatic compare_address(input string what,
			input function_generator_pkg::address_t expected,
			input function_generator_pkg::address_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s (%s): expected %h, actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic compare_count(input string what, input int expected, input int actual);
		check_count++;
		if (actual != expected) begin
			error_count++;
			$display("CHECK FAILED %s (%s): expected %0d, actual %0d",
				test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = error_count;
		test_count++;
	endtask

	task automatic end_test();
		$display("test %s finished, %0d errors", test_name, error_count - test_errors);
	endtask

	// hold reset for 16 cycles and check outputs just before release
	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		write_valid <= 1'b0;
		repeat (reset_cycles - 1) @(posedge clock);
		@(negedge clock);
		compare_bit("loaded in reset", 1'b0, loaded);
		compare_bit("bit_out in reset", 1'b0, bit_out);
		compare_bit("sample_strobe in reset", 1'b0, sample_strobe);
		@(posedge clock);
		reset <= 1'b0;
		build_model();
	endtask

	// counts edges from the release edge until loaded
	task automatic wait_loaded();
		int cycles;
		cycles = 0;
		while (cycles < 2 * fill_cycles) begin
			@(posedge clock);
			cycles++;
			@(negedge clock);
			if (loaded === 1'b1) begin
				break;
			end
			compare_bit("write_ready before loaded", 1'b0, write_ready);
		end
		if (loaded !== 1'b1) begin
			error_count++;
			$display("%s: loaded did not rise within %0d cycles", test_name, cycles);
		end
		compare_count("cycles to loaded", fill_cycles, cycles);
		compare_bit("write_ready with loaded", 1'b1, write_ready);
	endtask

	task automatic next_strobe();
		int waited;
		@(negedge clock);
		waited = 1;
		while (sample_strobe !== 1'b1 && waited < strobe_timeout) begin
			@(negedge clock);
			waited++;
		end
		if (sample_strobe !== 1'b1) begin
			error_count++;
			$display("%s: sample_strobe did not pulse within %0d cycles", test_name, waited);
		end
	endtask

	// one word at its strobe and optionally every serial bit after it
	task automatic check_word(input logic with_bits);
		function_generator_pkg::sample_t expected;
		expected = model[play_address];
		next_strobe();
		compare_sample("data_out", expected, data_out);
		if (with_bits) begin
			for (int b = data_width - 1; b >= 0; b--) begin
				compare_bit("bit_out", expected[b], bit_out);
				if (b > 0) begin
					@(negedge clock);
				end
			end
		end
		play_address = play_address + 1'b1;
	endtask

	// fill timing and a host write held off until loaded
	task automatic test_load();
		logic [31:0] value;
		function_generator_pkg::address_t held_address;
		function_generator_pkg::sample_t held_data;
		begin_test("load");
		random_bits(address_width, value);
		held_address = value[address_width-1:0];
		// address 0 is read on the same edge the write lands
		if (held_address == '0) begin
			held_address = 1'b1;
		end
		random_bits(data_width, value);
		held_data = value[data_width-1:0];
		apply_reset();
		write_valid <= 1'b1;
		write_address <= held_address;
		write_data <= held_data;
		wait_loaded();
		@(posedge clock);
		write_valid <= 1'b0;
		model[held_address] = held_data;
		end_test();
	endtask

	task automatic test_playback();
		begin_test("playback");
		// full loop and a few words past the wrap
		repeat (depth + 8) check_word(1'b0);
		end_test();
	endtask

	task automatic test_serial_bits();
		begin_test("serial bits");
		repeat (16) check_word(1'b1);
		end_test();
	endtask

	task automatic test_host_writes();
		logic [31:0] value;
		function_generator_pkg::address_t address;
		function_generator_pkg::address_t ahead;
		function_generator_pkg::sample_t data;
		begin_test("host writes");
		for (int w = 0; w < 10; w++) begin
			check_word(1'b0);
			repeat (2) begin
				random_bits(address_width, value);
				address = value[address_width-1:0];
				random_bits(data_width, value);
				data = value[data_width-1:0];
				// sample register and prefetch already hold the next two words
				ahead = play_address + 1'b1;
				if (address == play_address || address == ahead) begin
					address = play_address + 2'd2;
				end
				@(posedge clock);
				write_valid <= 1'b1;
				write_address <= address;
				write_data <= data;
				@(posedge clock);
				compare_bit("write_ready", 1'b1, write_ready);
				write_valid <= 1'b0;
				model[address] = data;
			end
		end
		// every address comes round once more
		repeat (depth) check_word(1'b0);
		end_test();
	endtask

	task automatic test_reset_restart();
		function_generator_pkg::sample_t first;
		function_generator_pkg::sample_t second;
		function_generator_pkg::address_t found;
		logic matched;
		begin_test("reset restart");
		check_word(1'b0);
		apply_reset();
		wait_loaded();
		next_strobe();
		first = data_out;
		next_strobe();
		second = data_out;
		// locate the first two played words in the fresh model
		found = '0;
		matched = 1'b0;
		for (int a = 0; a < depth; a++) begin
			if (!matched && model[a] == first && model[(a + 1) % depth] == second) begin
				found = function_generator_pkg::address_t'(a);
				matched = 1'b1;
			end
		end
		if (!matched) begin
			error_count++;
			$display("%s: played words after reset are not in the prbs sequence", test_name);
		end
		compare_address("first address after reset", '0, found);
		// playback after reset continues from address 2
		play_address = 2'd2;
		repeat (8) check_word(1'b1);
		end_test();
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		write_valid = 1'b0;
		write_address = '0;
		write_data = '0;
		random_state = 32'hb105b90a;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		test_load();
		test_playback();
		test_serial_bits();
		test_host_writes();
		test_reset_restart();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: function_generator_althea.f
rtl/function_generator_pkg.sv
rtl/prbs.sv
rtl/waveform_loader.sv
rtl/function_generator.sv
rtl/word_serializer.sv
rtl/function_generator_althea.sv
bench/function_generator_althea_asserts.sv
bench/function_generator_althea_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= function_generator_althea_tb
RTL_TOP ?= function_generator_althea
FILE_LIST ?= function_generator_althea.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
FAIL_PATTERN ?= Result: FAILED

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
RTL_SOURCES := $(filter rtl/%,$(SOURCES))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
